// ==== verilog/matmul_pkg.sv ====
package matmul_pkg;

  // Grid side, which is also the number of operand lanes
  parameter int MAT_SIZE = 4;
  parameter int DATA_W = 8;
  parameter int ADDR_W = 11;
  parameter int STRIDE_W = 8;

  // Multiply-accumulate depth: operand flop, product flop, accumulator
  parameter int MAC_LATENCY = 3;
  // Operand memories return data one cycle after the address
  parameter int MEM_LATENCY = 1;

  typedef logic [DATA_W-1:0] element_t;

  // Lane 0 sits in the low byte
  typedef element_t [MAT_SIZE-1:0] lane_word_t;

  typedef logic [7:0] cycle_cnt_t;

  // Indexed as [row][column]
  typedef element_t [MAT_SIZE-1:0][MAT_SIZE-1:0] result_matrix_t;

  // Full product, seen either as one word or as the fields the downcast looks at
  typedef union packed {
    logic [2*DATA_W-1:0] raw;
    struct packed {
      logic              sign;
      logic [DATA_W-1:0] ovf_field;
      logic [DATA_W-2:0] low_field;
    } f;
  } mac_product_t;

endpackage

// ==== verilog/systolic_feed_if.sv ====
interface systolic_feed_if;
  import matmul_pkg::*;

  // Skewed operand lanes entering the grid
  // A lane i enters row i at column 0, B lane j enters column j at row 0
  // A zero value contributes nothing to the accumulators
  element_t [MAT_SIZE-1:0] a_lane;
  element_t [MAT_SIZE-1:0] b_lane;

  // Each feeder drives only the lane set picked by its select parameter
  modport feeder (
    output a_lane,
    output b_lane
  );

  modport grid (
    input a_lane,
    input b_lane
  );

endinterface

// ==== verilog/matmul_sequencer.sv ====
module matmul_sequencer (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   i_start,
  output matmul_pkg::cycle_cnt_t o_cycle_cnt,
  output logic                   o_latch,
  output logic                   o_done
);
  import matmul_pkg::*;

  // Last product lands in the accumulators the cycle before this count
  localparam cycle_cnt_t LATCH_CNT = cycle_cnt_t'(3 * MAT_SIZE - 1 + MAC_LATENCY);
  // Four drain words follow the latch, then done
  localparam cycle_cnt_t DONE_CNT  = cycle_cnt_t'(4 * MAT_SIZE - 1 + MAC_LATENCY);
  localparam cycle_cnt_t HOLD_CNT  = DONE_CNT + cycle_cnt_t'(1);

  cycle_cnt_t cnt_q;
  logic       run_q;
  logic       done_q;

  // The count stays at zero on the edge that first sees start high
  // It then advances once per cycle and parks one past the done count
  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      cnt_q  <= '0;
      run_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      run_q  <= 1'b1;
      done_q <= (cnt_q == DONE_CNT);
      if (run_q && cnt_q != HOLD_CNT) begin
        cnt_q <= cnt_q + cycle_cnt_t'(1);
      end
    end
  end

  assign o_cycle_cnt = cnt_q;
  assign o_latch     = (cnt_q == LATCH_CNT);
  assign o_done      = done_q;

endmodule

// ==== verilog/operand_feeder.sv ====
module operand_feeder #(
  parameter int ADDR_W = matmul_pkg::ADDR_W,
  // Set for the B operand, clear for the A operand
  parameter bit FEED_B = 1'b0
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                i_start,
  input  matmul_pkg::cycle_cnt_t              i_cycle_cnt,
  input  logic [ADDR_W-1:0]                   i_base_addr,
  input  logic [matmul_pkg::STRIDE_W-1:0]     i_stride,
  output logic [ADDR_W-1:0]                   o_addr,
  input  matmul_pkg::lane_word_t              i_mem_word,
  input  logic [matmul_pkg::MAT_SIZE-1:0]     i_lane_mask,
  input  logic [matmul_pkg::MAT_SIZE-1:0]     i_inner_mask,
  systolic_feed_if.feeder                     feed
);
  import matmul_pkg::*;

  localparam int K_W = $clog2(MAT_SIZE);

  ////////////////////////////////////////
  // Address walk
  ////////////////////////////////////////

  logic [ADDR_W-1:0] addr_q;
  logic              addr_phase;

  // Base is presented at count 1, then one stride per cycle up to count 4
  always_ff @(posedge clk) begin
    if (i_cycle_cnt == '0) begin
      addr_q <= i_base_addr;
    end else if (i_cycle_cnt < cycle_cnt_t'(MAT_SIZE)) begin
      addr_q <= addr_q + ADDR_W'(i_stride);
    end
  end

  assign o_addr     = addr_q;
  assign addr_phase = (i_cycle_cnt >= cycle_cnt_t'(1)) &&
                      (i_cycle_cnt <= cycle_cnt_t'(MAT_SIZE));

  ////////////////////////////////////////
  // Returning data and masking
  ////////////////////////////////////////

  logic [MEM_LATENCY-1:0] phase_q;
  logic [K_W-1:0]         word_k;
  logic                   data_ok;
  lane_word_t             masked;

  // Address phase delayed by the memory latency marks the returning words
  // Word k of the walk is inner index k of the product
  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      phase_q <= '0;
      word_k  <= '0;
    end else begin
      phase_q[0] <= addr_phase;
      for (int n = 1; n < MEM_LATENCY; n++) begin
        phase_q[n] <= phase_q[n-1];
      end
      if (phase_q[MEM_LATENCY-1]) begin
        word_k <= word_k + K_W'(1);
      end
    end
  end

  assign data_ok = phase_q[MEM_LATENCY-1] && i_inner_mask[word_k];

  always_comb begin
    for (int i = 0; i < MAT_SIZE; i++) begin
      masked[i] = (data_ok && i_lane_mask[i]) ? i_mem_word[i] : '0;
    end
  end

  ////////////////////////////////////////
  // Skew
  ////////////////////////////////////////

  lane_word_t skewed;

  // Lane 0 enters the grid without delay
  assign skewed[0] = masked[0];

  generate
    // Lane i waits in a chain of i registers, all cleared at cycle 0
    for (genvar i = 1; i < MAT_SIZE; i++) begin : g_skew
      element_t dly_q [i];

      always_ff @(posedge clk) begin
        if (reset || !i_start || i_cycle_cnt == '0) begin
          for (int d = 0; d < i; d++) begin
            dly_q[d] <= '0;
          end
        end else begin
          dly_q[0] <= masked[i];
          for (int d = 1; d < i; d++) begin
            dly_q[d] <= dly_q[d-1];
          end
        end
      end

      assign skewed[i] = dly_q[i-1];
    end
  endgenerate

  generate
    if (FEED_B) begin : g_feed_b
      assign feed.b_lane = skewed;
    end else begin : g_feed_a
      assign feed.a_lane = skewed;
    end
  endgenerate

endmodule

// ==== verilog/processing_element.sv ====
module processing_element (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 i_clear,
  input  matmul_pkg::element_t i_a,
  input  matmul_pkg::element_t i_b,
  output matmul_pkg::element_t o_a,
  output matmul_pkg::element_t o_b,
  output matmul_pkg::element_t o_c
);
  import matmul_pkg::*;

  element_t     a_fwd_q;
  element_t     b_fwd_q;
  element_t     a_mul_q;
  element_t     b_mul_q;
  mac_product_t prod_q;
  element_t     prod_small;
  element_t     acc_q;

  // Operands move on to the right and lower neighbours one cycle later
  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      a_fwd_q <= '0;
      b_fwd_q <= '0;
    end else begin
      a_fwd_q <= i_a;
      b_fwd_q <= i_b;
    end
  end

  // Multiplier input flops and product flop
  always_ff @(posedge clk) begin
    a_mul_q    <= i_a;
    b_mul_q    <= i_b;
    prod_q.raw <= {{DATA_W{1'b0}}, a_mul_q} * {{DATA_W{1'b0}}, b_mul_q};
  end

  // Downcast to one element
  // Positive values saturate to the largest positive code when the overflow
  // field has any bit set, negative values clamp to the most negative code
  // when it has none
  always_comb begin
    if (!prod_q.f.sign) begin
      if (|prod_q.f.ovf_field) begin
        prod_small = {1'b0, {(DATA_W-1){1'b1}}};
      end else begin
        prod_small = {1'b0, prod_q.f.low_field};
      end
    end else begin
      if (|prod_q.f.ovf_field) begin
        prod_small = {1'b1, prod_q.f.low_field};
      end else begin
        prod_small = {1'b1, {(DATA_W-1){1'b0}}};
      end
    end
  end

  // Accumulate wraps at the element width
  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      acc_q <= '0;
    end else begin
      acc_q <= acc_q + prod_small;
    end
  end

  assign o_a = a_fwd_q;
  assign o_b = b_fwd_q;
  assign o_c = acc_q;

endmodule

// ==== verilog/systolic_array.sv ====
module systolic_array (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       i_clear,
  systolic_feed_if.grid              feed,
  output matmul_pkg::result_matrix_t o_result
);
  import matmul_pkg::*;

  // A links run along each row, one extra column for the right edge
  element_t a_link [MAT_SIZE][MAT_SIZE+1];
  // B links run down each column, one extra row for the bottom edge
  element_t b_link [MAT_SIZE+1][MAT_SIZE];

  genvar i;
  genvar j;

  generate
    for (i = 0; i < MAT_SIZE; i++) begin : g_edge
      // Skewed lanes enter at the left column and the top row
      assign a_link[i][0] = feed.a_lane[i];
      assign b_link[0][i] = feed.b_lane[i];
    end

    for (i = 0; i < MAT_SIZE; i++) begin : g_row
      for (j = 0; j < MAT_SIZE; j++) begin : g_col
        // Element (i, j) sees A row i and B column j in step, so it builds C[i][j]
        processing_element u_pe (
          .clk     (clk),
          .reset   (reset),
          .i_clear (i_clear),
          .i_a     (a_link[i][j]),
          .i_b     (b_link[i][j]),
          .o_a     (a_link[i][j+1]),
          .o_b     (b_link[i+1][j]),
          .o_c     (o_result[i][j])
        );
      end
    end
  endgenerate

endmodule

// ==== verilog/result_drain.sv ====
module result_drain #(
  parameter int ADDR_W = matmul_pkg::ADDR_W
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            i_start,
  input  logic                            i_latch,
  input  matmul_pkg::result_matrix_t      i_result,
  input  logic [ADDR_W-1:0]               i_base_addr,
  input  logic [matmul_pkg::STRIDE_W-1:0] i_stride,
  output logic [ADDR_W-1:0]               o_c_addr,
  output matmul_pkg::lane_word_t          o_c_data,
  output logic                            o_c_data_available
);
  import matmul_pkg::*;

  localparam int WORD_W = $clog2(MAT_SIZE);

  lane_word_t        col_q [MAT_SIZE];
  logic [ADDR_W-1:0] addr_q;
  logic [WORD_W-1:0] word_cnt;
  logic              avail_q;

  // Column n of C goes out as one word, row r in byte r
  // Zeros fill in behind as the columns shift toward the output
  always_ff @(posedge clk) begin
    if (i_latch) begin
      addr_q <= i_base_addr;
      for (int n = 0; n < MAT_SIZE; n++) begin
        for (int r = 0; r < MAT_SIZE; r++) begin
          col_q[n][r] <= i_result[r][n];
        end
      end
    end else if (avail_q) begin
      addr_q <= addr_q - ADDR_W'(i_stride);
      for (int n = 0; n < MAT_SIZE - 1; n++) begin
        col_q[n] <= col_q[n+1];
      end
      col_q[MAT_SIZE-1] <= '0;
    end
  end

  // Availability lasts exactly one word per column
  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      avail_q  <= 1'b0;
      word_cnt <= '0;
    end else if (i_latch) begin
      avail_q  <= 1'b1;
      word_cnt <= '0;
    end else if (avail_q) begin
      word_cnt <= word_cnt + WORD_W'(1);
      if (word_cnt == WORD_W'(MAT_SIZE - 1)) begin
        avail_q <= 1'b0;
      end
    end
  end

  assign o_c_addr           = addr_q;
  assign o_c_data           = col_q[0];
  assign o_c_data_available = avail_q;

endmodule

// ==== verilog/matmul_4x4_systolic.sv ====
module matmul_4x4_systolic #(
  parameter int ADDR_W = matmul_pkg::ADDR_W
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            i_start_mat_mul,
  output logic                            o_done_mat_mul,
  input  logic [ADDR_W-1:0]               i_address_mat_a,
  input  logic [matmul_pkg::STRIDE_W-1:0] i_address_stride_a,
  input  matmul_pkg::lane_word_t          i_a_data,
  output logic [ADDR_W-1:0]               o_a_addr,
  input  logic [ADDR_W-1:0]               i_address_mat_b,
  input  logic [matmul_pkg::STRIDE_W-1:0] i_address_stride_b,
  input  matmul_pkg::lane_word_t          i_b_data,
  output logic [ADDR_W-1:0]               o_b_addr,
  input  logic [ADDR_W-1:0]               i_address_mat_c,
  input  logic [matmul_pkg::STRIDE_W-1:0] i_address_stride_c,
  output logic [ADDR_W-1:0]               o_c_addr,
  output matmul_pkg::lane_word_t          o_c_data,
  output logic                            o_c_data_available,
  input  logic [matmul_pkg::MAT_SIZE-1:0] i_validity_mask_a_rows,
  input  logic [matmul_pkg::MAT_SIZE-1:0] i_validity_mask_a_cols_b_rows,
  input  logic [matmul_pkg::MAT_SIZE-1:0] i_validity_mask_b_cols
);
  import matmul_pkg::*;

  cycle_cnt_t     cycle_cnt;
  logic           latch;
  logic           pe_clear;
  result_matrix_t result;

  systolic_feed_if feed_bus ();

  // Accumulators hold zero whenever no run is in progress
  assign pe_clear = !i_start_mat_mul;

  matmul_sequencer u_sequencer (
    .clk         (clk),
    .reset       (reset),
    .i_start     (i_start_mat_mul),
    .o_cycle_cnt (cycle_cnt),
    .o_latch     (latch),
    .o_done      (o_done_mat_mul)
  );

  ////////////////////////////////////////
  // Operand feeders
  ////////////////////////////////////////

  // A words are columns of A, so the row mask picks lanes
  operand_feeder #(.ADDR_W(ADDR_W), .FEED_B(1'b0)) u_feed_a (
    .clk          (clk),
    .reset        (reset),
    .i_start      (i_start_mat_mul),
    .i_cycle_cnt  (cycle_cnt),
    .i_base_addr  (i_address_mat_a),
    .i_stride     (i_address_stride_a),
    .o_addr       (o_a_addr),
    .i_mem_word   (i_a_data),
    .i_lane_mask  (i_validity_mask_a_rows),
    .i_inner_mask (i_validity_mask_a_cols_b_rows),
    .feed         (feed_bus.feeder)
  );

  // B words are rows of B, so the column mask picks lanes
  operand_feeder #(.ADDR_W(ADDR_W), .FEED_B(1'b1)) u_feed_b (
    .clk          (clk),
    .reset        (reset),
    .i_start      (i_start_mat_mul),
    .i_cycle_cnt  (cycle_cnt),
    .i_base_addr  (i_address_mat_b),
    .i_stride     (i_address_stride_b),
    .o_addr       (o_b_addr),
    .i_mem_word   (i_b_data),
    .i_lane_mask  (i_validity_mask_b_cols),
    .i_inner_mask (i_validity_mask_a_cols_b_rows),
    .feed         (feed_bus.feeder)
  );

  systolic_array u_array (
    .clk      (clk),
    .reset    (reset),
    .i_clear  (pe_clear),
    .feed     (feed_bus.grid),
    .o_result (result)
  );

  result_drain #(.ADDR_W(ADDR_W)) u_drain (
    .clk                (clk),
    .reset              (reset),
    .i_start            (i_start_mat_mul),
    .i_latch            (latch),
    .i_result           (result),
    .i_base_addr        (i_address_mat_c),
    .i_stride           (i_address_stride_c),
    .o_c_addr           (o_c_addr),
    .o_c_data           (o_c_data),
    .o_c_data_available (o_c_data_available)
  );

endmodule

// ==== verif/matmul_assertions.sv ====
module matmul_assertions (
  input logic clk,
  input logic reset,
  input logic i_start,
  input logic i_done,
  input logic i_c_data_available
);
  timeunit 1ns;
  timeprecision 1ps;

  // Done is a single pulse at the end of a run
  done_one_cycle: assert property (@(posedge clk) disable iff (reset)
    i_done |=> !i_done)
    else $error("o_done_mat_mul stayed high for more than one cycle");

  // No result word can leave the tile unless a run is in progress
  avail_needs_start: assert property (@(posedge clk) disable iff (reset)
    !i_start |-> !i_c_data_available)
    else $error("o_c_data_available high while i_start_mat_mul is low");

  // Done comes strictly after the last result word
  done_after_words: assert property (@(posedge clk) disable iff (reset)
    !(i_done && i_c_data_available))
    else $error("o_done_mat_mul and o_c_data_available high in the same cycle");

endmodule

bind matmul_4x4_systolic matmul_assertions u_assertions (
  .clk                (clk),
  .reset              (reset),
  .i_start            (i_start_mat_mul),
  .i_done             (o_done_mat_mul),
  .i_c_data_available (o_c_data_available)
);

// ==== verif/matmul_checker.sv ====
module matmul_checker #(
  parameter int ADDR_W = matmul_pkg::ADDR_W
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            i_start,
  input  logic                            i_done,
  input  logic [ADDR_W-1:0]               i_base_a,
  input  logic [matmul_pkg::STRIDE_W-1:0] i_stride_a,
  input  logic [ADDR_W-1:0]               i_base_b,
  input  logic [matmul_pkg::STRIDE_W-1:0] i_stride_b,
  input  logic [ADDR_W-1:0]               i_base_c,
  input  logic [matmul_pkg::STRIDE_W-1:0] i_stride_c,
  input  logic [matmul_pkg::MAT_SIZE-1:0] i_mask_rows,
  input  logic [matmul_pkg::MAT_SIZE-1:0] i_mask_inner,
  input  logic [matmul_pkg::MAT_SIZE-1:0] i_mask_cols,
  input  logic [ADDR_W-1:0]               i_a_addr,
  input  logic [ADDR_W-1:0]               i_b_addr,
  input  logic [ADDR_W-1:0]               i_c_addr,
  input  matmul_pkg::lane_word_t          i_c_data,
  input  logic                            i_c_avail,
  input  matmul_pkg::lane_word_t          i_mem_a [2**ADDR_W],
  input  matmul_pkg::lane_word_t          i_mem_b [2**ADDR_W],
  output int                              o_error_count,
  output int                              o_runs,
  output int                              o_words
);
  timeunit 1ns;
  timeprecision 1ps;
  import matmul_pkg::*;

  // Run counter values, zero being the cycle right after the start edge
  localparam int FIRST_WORD_CYCLE = 3 * MAT_SIZE + MAC_LATENCY;
  localparam int DONE_CYCLE       = FIRST_WORD_CYCLE + MAT_SIZE;

  element_t              exp_c [MAT_SIZE][MAT_SIZE];
  logic [ADDR_W-1:0]     base_a;
  logic [ADDR_W-1:0]     base_b;
  logic [ADDR_W-1:0]     base_c;
  logic [STRIDE_W-1:0]   stride_a;
  logic [STRIDE_W-1:0]   stride_b;
  logic [STRIDE_W-1:0]   stride_c;
  logic                  prev_start;
  int                    cyc;
  int                    words_seen;
  int                    dones_seen;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Unsigned product folded back to one element
  // Sign clear: saturate on any overflow bit, sign set: clamp when none is set
  function automatic element_t downcast(input element_t a, input element_t b);
    mac_product_t p;
    p.raw = {{DATA_W{1'b0}}, a} * {{DATA_W{1'b0}}, b};
    if (!p.f.sign) begin
      if (p.f.ovf_field != '0) return 8'h7f;
      return {1'b0, p.f.low_field};
    end
    if (p.f.ovf_field != '0) return {1'b1, p.f.low_field};
    return 8'h80;
  endfunction

  // Address k of a walk, wrapping at the memory size
  function automatic logic [ADDR_W-1:0] walk_addr(input logic [ADDR_W-1:0] base,
                                                  input logic [STRIDE_W-1:0] stride,
                                                  input int k, input bit descending);
    logic [ADDR_W-1:0] offset;
    offset = ADDR_W'(k * int'(stride));
    if (descending) return base - offset;
    return base + offset;
  endfunction

  // Column j of C as it leaves the tile, row r in byte r
  function automatic lane_word_t column_word(input int j);
    lane_word_t w;
    for (int r = 0; r < MAT_SIZE; r++) begin
      w[r] = exp_c[r][j];
    end
    return w;
  endfunction

  // A word k is column k of A, B word k is row k of B
  // Masked operands are zero before they reach the multiply
  task automatic build_expected();
    lane_word_t a_word;
    lane_word_t b_word;
    element_t   a_el;
    element_t   b_el;
    for (int i = 0; i < MAT_SIZE; i++) begin
      for (int j = 0; j < MAT_SIZE; j++) begin
        exp_c[i][j] = '0;
      end
    end
    for (int k = 0; k < MAT_SIZE; k++) begin
      a_word = i_mem_a[walk_addr(base_a, stride_a, k, 1'b0)];
      b_word = i_mem_b[walk_addr(base_b, stride_b, k, 1'b0)];
      for (int i = 0; i < MAT_SIZE; i++) begin
        for (int j = 0; j < MAT_SIZE; j++) begin
          a_el = (i_mask_inner[k] && i_mask_rows[i]) ? a_word[i] : '0;
          b_el = (i_mask_inner[k] && i_mask_cols[j]) ? b_word[j] : '0;
          exp_c[i][j] = exp_c[i][j] + downcast(a_el, b_el);
        end
      end
    end
  endtask

  ////////////////////////////////////////
  // Comparison
  ////////////////////////////////////////

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual) begin
      o_error_count++;
      $display("[ERROR] %s in run %0d cycle %0d: expected 0x%0h, actual 0x%0h",
               name, o_runs, cyc, expected, actual);
    end
  endtask

  // Outputs sampled here belong to run cycle cyc
  task automatic check_cycle();
    logic exp_avail;
    logic exp_done;
    exp_avail = (cyc >= FIRST_WORD_CYCLE) && (cyc < DONE_CYCLE);
    exp_done  = (cyc == DONE_CYCLE);
    if (cyc >= 1 && cyc <= MAT_SIZE) begin
      compare_value("o_a_addr", 32'(walk_addr(base_a, stride_a, cyc - 1, 1'b0)),
                    32'(i_a_addr));
      compare_value("o_b_addr", 32'(walk_addr(base_b, stride_b, cyc - 1, 1'b0)),
                    32'(i_b_addr));
    end
    compare_value("o_c_data_available", 32'(exp_avail), 32'(i_c_avail));
    compare_value("o_done_mat_mul", 32'(exp_done), 32'(i_done));
    if (i_c_avail) begin
      if (words_seen < MAT_SIZE) begin
        compare_value("o_c_addr", 32'(walk_addr(base_c, stride_c, words_seen, 1'b1)),
                      32'(i_c_addr));
        compare_value("o_c_data", column_word(words_seen), i_c_data);
      end
      words_seen++;
      o_words++;
    end
    if (i_done) begin
      dones_seen++;
    end
  endtask

  always @(posedge clk) begin
    if (reset) begin
      prev_start    = 1'b0;
      cyc           = 0;
      o_error_count = 0;
      o_runs        = 0;
      o_words       = 0;
    end else begin
      if (prev_start) begin
        check_cycle();
      end else begin
        // Between runs the tile stays silent
        compare_value("o_c_data_available", 32'h0, 32'(i_c_avail));
        compare_value("o_done_mat_mul", 32'h0, 32'(i_done));
      end
      if (i_start && !prev_start) begin
        base_a     = i_base_a;
        base_b     = i_base_b;
        base_c     = i_base_c;
        stride_a   = i_stride_a;
        stride_b   = i_stride_b;
        stride_c   = i_stride_c;
        cyc        = 0;
        words_seen = 0;
        dones_seen = 0;
        o_runs++;
        build_expected();
      end else if (i_start) begin
        cyc++;
      end else if (prev_start && (words_seen != MAT_SIZE || dones_seen != 1)) begin
        o_error_count++;
        $display("Run %0d gave %0d result words and %0d done pulses instead of %0d and 1",
                 o_runs, words_seen, dones_seen, MAT_SIZE);
      end
      prev_start = i_start;
    end
  end

endmodule

// ==== verif/tb_matmul.sv ====
module tb_matmul;
  timeunit 1ns;
  timeprecision 1ps;
  import matmul_pkg::*;

  localparam int          MEM_WORDS    = 2 ** ADDR_W;
  localparam int          NUM_RUNS     = 40;
  localparam int          FULL_RUNS    = 8;
  localparam int          RESET_CYCLES = 16;
  localparam int          DONE_TIMEOUT = 64;
  localparam logic [31:0] SEED         = 32'h70027112;

  logic                clk = 1'b0;
  logic                reset;
  logic                start;
  logic [ADDR_W-1:0]   base_a;
  logic [ADDR_W-1:0]   base_b;
  logic [ADDR_W-1:0]   base_c;
  logic [STRIDE_W-1:0] stride_a;
  logic [STRIDE_W-1:0] stride_b;
  logic [STRIDE_W-1:0] stride_c;
  logic [MAT_SIZE-1:0] mask_rows;
  logic [MAT_SIZE-1:0] mask_inner;
  logic [MAT_SIZE-1:0] mask_cols;
  lane_word_t          a_data = '0;
  lane_word_t          b_data = '0;
  logic [ADDR_W-1:0]   a_addr_d = '0;
  logic [ADDR_W-1:0]   b_addr_d = '0;
  logic [ADDR_W-1:0]   a_addr;
  logic [ADDR_W-1:0]   b_addr;
  logic [ADDR_W-1:0]   c_addr;
  lane_word_t          c_data;
  logic                c_avail;
  logic                done;
  lane_word_t          mem_a [MEM_WORDS];
  lane_word_t          mem_b [MEM_WORDS];
  logic [31:0]         rng_state;
  logic                timed_out;
  int                  error_count;
  int                  runs_checked;
  int                  words_checked;

  always #50 clk = ~clk;

  matmul_4x4_systolic #(.ADDR_W(ADDR_W)) uut (
    .clk                           (clk),
    .reset                         (reset),
    .i_start_mat_mul               (start),
    .o_done_mat_mul                (done),
    .i_address_mat_a               (base_a),
    .i_address_stride_a            (stride_a),
    .i_a_data                      (a_data),
    .o_a_addr                      (a_addr),
    .i_address_mat_b               (base_b),
    .i_address_stride_b            (stride_b),
    .i_b_data                      (b_data),
    .o_b_addr                      (b_addr),
    .i_address_mat_c               (base_c),
    .i_address_stride_c            (stride_c),
    .o_c_addr                      (c_addr),
    .o_c_data                      (c_data),
    .o_c_data_available            (c_avail),
    .i_validity_mask_a_rows        (mask_rows),
    .i_validity_mask_a_cols_b_rows (mask_inner),
    .i_validity_mask_b_cols        (mask_cols)
  );

  matmul_checker #(.ADDR_W(ADDR_W)) u_checker (
    .clk           (clk),
    .reset         (reset),
    .i_start       (start),
    .i_done        (done),
    .i_base_a      (base_a),
    .i_stride_a    (stride_a),
    .i_base_b      (base_b),
    .i_stride_b    (stride_b),
    .i_base_c      (base_c),
    .i_stride_c    (stride_c),
    .i_mask_rows   (mask_rows),
    .i_mask_inner  (mask_inner),
    .i_mask_cols   (mask_cols),
    .i_a_addr      (a_addr),
    .i_b_addr      (b_addr),
    .i_c_addr      (c_addr),
    .i_c_data      (c_data),
    .i_c_avail     (c_avail),
    .i_mem_a       (mem_a),
    .i_mem_b       (mem_b),
    .o_error_count (error_count),
    .o_runs        (runs_checked),
    .o_words       (words_checked)
  );

  // Operand memories return the word one cycle after they see its address
  always @(negedge clk) begin
    a_data   <= mem_a[a_addr_d];
    b_data   <= mem_b[b_addr_d];
    a_addr_d <= a_addr;
    b_addr_d <= b_addr;
  end

  ////////////////////////////////////////
  // Random source
  ////////////////////////////////////////

  function automatic logic [31:0] next_random(input logic [31:0] state);
    logic [31:0] x;
    x = state ^ (state << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic draw_random(output logic [31:0] value);
    rng_state = next_random(rng_state);
    value     = rng_state;
  endtask

  // Polls done on each falling edge, gives up after DONE_TIMEOUT cycles
  task automatic wait_for_done(output logic expired);
    int cycles;
    cycles = 0;
    while (!done && cycles < DONE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    expired = !done;
  endtask

  initial begin
    logic [31:0] r;
    int          hold;
    int          gap;
    reset      = 1'b1;
    start      = 1'b0;
    base_a     = '0;
    base_b     = '0;
    base_c     = '0;
    stride_a   = '0;
    stride_b   = '0;
    stride_c   = '0;
    mask_rows  = '1;
    mask_inner = '1;
    mask_cols  = '1;
    timed_out  = 1'b0;
    rng_state  = SEED;
    for (int n = 0; n < MEM_WORDS; n++) begin
      draw_random(r);
      mem_a[n] = r;
      draw_random(r);
      mem_b[n] = r;
    end
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    for (int run = 0; run < NUM_RUNS && !timed_out; run++) begin
      draw_random(r);
      base_a   = r[ADDR_W-1:0];
      stride_a = r[ADDR_W+STRIDE_W-1:ADDR_W];
      draw_random(r);
      base_b   = r[ADDR_W-1:0];
      stride_b = r[ADDR_W+STRIDE_W-1:ADDR_W];
      draw_random(r);
      base_c   = r[ADDR_W-1:0];
      stride_c = r[ADDR_W+STRIDE_W-1:ADDR_W];
      draw_random(r);
      // The first runs keep every row, column and inner term
      if (run >= FULL_RUNS) begin
        mask_rows  = r[MAT_SIZE-1:0];
        mask_inner = r[2*MAT_SIZE-1:MAT_SIZE];
        mask_cols  = r[3*MAT_SIZE-1:2*MAT_SIZE];
      end
      hold  = int'(r[17:16]);
      gap   = (run % 2 == 0) ? 0 : int'(r[19:18]);
      start = 1'b1;
      wait_for_done(timed_out);
      if (timed_out) begin
        $display("Timed out after %0d cycles waiting for o_done_mat_mul in run %0d",
                 DONE_TIMEOUT, run);
      end
      // Start may stay high after done, the tile must stay quiet meanwhile
      repeat (hold) @(negedge clk);
      start = 1'b0;
      repeat (gap + 1) @(negedge clk);
    end

    repeat (4) @(negedge clk);
    $display("Checked %0d runs and %0d result words with %0d errors",
             runs_checked, words_checked, error_count);
    if (error_count == 0 && !timed_out) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== matmul_4x4_systolic.f ====
verilog/matmul_pkg.sv
verilog/systolic_feed_if.sv
verilog/matmul_sequencer.sv
verilog/operand_feeder.sv
verilog/processing_element.sv
verilog/systolic_array.sv
verilog/result_drain.sv
verilog/matmul_4x4_systolic.sv
verif/matmul_assertions.sv
verif/matmul_checker.sv
verif/tb_matmul.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_matmul
RTL_TOP    := matmul_4x4_systolic
FILELIST   := matmul_4x4_systolic.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
